//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_pkg.sv
      - verilog/dcache_arrays.sv
      - verilog/dcache_lookup.sv
      - verilog/dcache_ctrl.sv
      - verilog/dcache_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verif/dcache_l2_model.sv
      - verif/dcache_tb.sv

//--- dcache_top.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_arrays.sv
verilog/dcache_lookup.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verif/dcache_l2_model.sv
verif/dcache_tb.sv

//--- verif/dcache_l2_model.sv
// behavioral l2 memory with fixed response delay, request counters and last write record
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_l2_model (
    input  logic                  clk_tmp,
    input  logic                  rst_n,
    input  logic                  l2_req_valid,
    input  dcache_pkg::l2_req_t   l2_req,
    output logic                  l2_rsp_valid,
    output logic [`DC_LINE_W-1:0] l2_rdata,
    output int                    rd_count,
    output int                    wr_count,
    output dcache_pkg::l2_req_t   last_wr
);
    import dcache_pkg::*;

    localparam int          RSP_DELAY = 3;
    localparam logic [31:0] FILL_XOR  = 32'h5A3C_96E1;  // unwritten word = address ^ this

    logic [`DC_LINE_W-1:0] line_mem [logic [`DC_ADDR_W-1:0]];  // sparse, keyed by line address
    l2_req_t               pending;
    int                    delay_cnt;

    function automatic logic [`DC_LINE_W-1:0] read_line(input logic [`DC_ADDR_W-1:0] line_addr);
        logic [`DC_LINE_W-1:0] line;
        if (line_mem.exists(line_addr)) begin
            line = line_mem[line_addr];
        end else begin
            for (int i = 0; i < 4; i++) begin
                line[i*`DC_WORD_W +: `DC_WORD_W] = (line_addr + 4*i) ^ FILL_XOR;
            end
        end
        return line;
    endfunction

    always @(posedge clk_tmp or negedge rst_n) begin
        if (!rst_n) begin
            l2_rsp_valid <= 1'b0;
            l2_rdata     <= '0;
            pending      <= '0;
            delay_cnt    <= 0;
            rd_count     <= 0;
            wr_count     <= 0;
            last_wr      <= '0;
        end else begin
            l2_rsp_valid <= 1'b0;
            if (l2_req_valid) begin
                pending   <= l2_req;
                delay_cnt <= RSP_DELAY;
                if (l2_req.op == MEM_WRITE) begin
                    line_mem[{l2_req.addr[`DC_ADDR_W-1:4], 4'b0}] = l2_req.line;
                    wr_count <= wr_count + 1;
                    last_wr  <= l2_req;
                end else begin
                    rd_count <= rd_count + 1;
                end
            end else if (delay_cnt > 0) begin
                delay_cnt <= delay_cnt - 1;
                if (delay_cnt == 1) begin  // third edge after the strobe
                    l2_rsp_valid <= 1'b1;
                    l2_rdata     <= (pending.op == MEM_READ) ?
                                    read_line({pending.addr[`DC_ADDR_W-1:4], 4'b0}) : '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/dcache_tb.sv
// clock, reset, directed tests, compare tasks, reference memory and watchdog of the data cache
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int          CLK_PERIOD      = 100;
    localparam int          DRIVE_DELAY     = 10;
    localparam int          ACCESS_TIMEOUT  = 40;        // cycles per access
    localparam int          WATCHDOG_CYCLES = 200 * 40;
    localparam logic [31:0] FILL_XOR        = 32'h5A3C_96E1;

    logic                  clk_tmp;
    logic                  rst_n;
    logic                  cpu_req_valid;
    cpu_req_t              cpu_req;
    logic                  busy;
    logic                  cpu_rsp_valid;
    logic [`DC_WORD_W-1:0] cpu_rdata;
    logic                  l2_req_valid;
    l2_req_t               l2_req;
    logic                  l2_rsp_valid;
    logic [`DC_LINE_W-1:0] l2_rdata;
    int                    l2_rd_count;
    int                    l2_wr_count;
    l2_req_t               l2_last_wr;

    int                    errors;
    int                    checks;
    logic [31:0]           rng;
    logic [31:0]           ref_mem [logic [31:0]];  // word address -> word

    dcache_top dcache_top_inst (
        .clk_tmp       (clk_tmp),
        .rst_n         (rst_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .busy          (busy),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rdata     (cpu_rdata),
        .l2_req_valid  (l2_req_valid),
        .l2_req        (l2_req),
        .l2_rsp_valid  (l2_rsp_valid),
        .l2_rdata      (l2_rdata)
    );

    dcache_l2_model l2_model_inst (
        .clk_tmp      (clk_tmp),
        .rst_n        (rst_n),
        .l2_req_valid (l2_req_valid),
        .l2_req       (l2_req),
        .l2_rsp_valid (l2_rsp_valid),
        .l2_rdata     (l2_rdata),
        .rd_count     (l2_rd_count),
        .wr_count     (l2_wr_count),
        .last_wr      (l2_last_wr)
    );

    initial begin
        clk_tmp = 1'b0;
        forever #(CLK_PERIOD / 2) clk_tmp = ~clk_tmp;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // tag | index | word offset | byte offset
    function automatic logic [31:0] make_addr(input logic [19:0] tag, input logic [7:0] index,
                                              input logic [1:0] offset);
        return {tag, index, offset, 2'b00};
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a ^ FILL_XOR;
    endfunction

    function automatic logic [`DC_LINE_W-1:0] ref_line(input logic [31:0] line_addr);
        logic [`DC_LINE_W-1:0] line;
        for (int i = 0; i < 4; i++) begin
            line[i*32 +: 32] = ref_read(line_addr + 4*i);
        end
        return line;
    endfunction

    task automatic compare_word(input string name, input logic [`DC_WORD_W-1:0] exp,
                                input logic [`DC_WORD_W-1:0] act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_l2_req(input string name, input l2_req_t exp, input l2_req_t act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %s: expected op %0d addr %h line %h, actual op %0d addr %h line %h",
                     name, exp.op, exp.addr, exp.line, act.op, act.addr, act.line);
            errors++;
        end
    endtask

    // called 10 ns after a rising edge, returns 10 ns after the response edge
    task automatic cpu_access(input string name, input mem_op_e op, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int latency);
        logic got;
        if (busy && !cpu_rsp_valid) begin
            $display("%s: request issued while the cache is still busy", name);
            errors++;
        end
        cpu_req_valid = 1'b1;
        cpu_req.op    = op;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        @(posedge clk_tmp);  // request edge
        #(DRIVE_DELAY);
        cpu_req_valid = 1'b0;
        latency = 0;
        got = 1'b0;
        while (!got && latency < ACCESS_TIMEOUT) begin
            @(posedge clk_tmp);
            #(DRIVE_DELAY);
            latency++;
            got = cpu_rsp_valid;
            compare_flag({name, " busy"}, 1'b1, busy);  // held until the response drops
        end
        if (!got) begin
            $display("%s: no response within %0d cycles for address %h", name, ACCESS_TIMEOUT,
                     addr);
            errors++;
        end
        rdata = cpu_rdata;
    endtask

    task automatic read_check(input string name, input logic [31:0] addr, output int latency);
        logic [31:0] rdata;
        cpu_access(name, MEM_READ, addr, '0, rdata, latency);
        compare_word(name, ref_read(addr), rdata);
    endtask

    task automatic write_check(input string name, input logic [31:0] addr,
                               input logic [31:0] wdata, output int latency);
        logic [31:0] rdata;
        cpu_access(name, MEM_WRITE, addr, wdata, rdata, latency);
        ref_mem[{addr[31:2], 2'b00}] = wdata;
        compare_word(name, wdata, rdata);  // write echoes the stored word
    endtask

    task automatic read_miss_clean_set();
        int lat;
        int rd0;
        rd0 = l2_rd_count;
        read_check("read_miss", make_addr(20'h00010, 8'h05, 2'd1), lat);
        compare_count("read_miss l2 reads", rd0 + 1, l2_rd_count);
    endtask

    task automatic read_hit_same_line();
        int lat;
        int rd0;
        int wr0;
        rd0 = l2_rd_count;
        wr0 = l2_wr_count;
        read_check("read_hit", make_addr(20'h00010, 8'h05, 2'd2), lat);
        compare_count("read_hit latency", 2, lat);
        compare_count("read_hit l2 reads", rd0, l2_rd_count);
        compare_count("read_hit l2 writes", wr0, l2_wr_count);
    endtask

    task automatic write_hit_merge();
        int lat;
        int rd0;
        int wr0;
        rd0 = l2_rd_count;
        wr0 = l2_wr_count;
        write_check("write_hit", make_addr(20'h00010, 8'h05, 2'd3), 32'hC0DE_0003, lat);
        compare_count("write_hit latency", 2, lat);
        for (int off = 0; off < 4; off++) begin
            read_check($sformatf("write_hit readback word %0d", off),
                       make_addr(20'h00010, 8'h05, off[1:0]), lat);
        end
        compare_count("write_hit l2 reads", rd0, l2_rd_count);
        compare_count("write_hit l2 writes", wr0, l2_wr_count);
    endtask

    // lines a..e share set 0x20, only a is ever dirty
    task automatic lru_eviction();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        l2_req_t     exp_wb;
        int          lat;
        int          rd0;
        int          wr0;
        a = make_addr(20'h0A000, 8'h20, 2'd1);
        b = make_addr(20'h0B000, 8'h20, 2'd0);
        c = make_addr(20'h0C000, 8'h20, 2'd2);
        d = make_addr(20'h0D000, 8'h20, 2'd3);
        e = make_addr(20'h0E000, 8'h20, 2'd0);
        read_check("lru fill A", a, lat);
        read_check("lru fill B", b, lat);
        read_check("lru touch A", a, lat);  // b is now least recent
        compare_count("lru touch A latency", 2, lat);
        rd0 = l2_rd_count;
        wr0 = l2_wr_count;
        read_check("lru fill C", c, lat);
        compare_count("lru fill C l2 reads", rd0 + 1, l2_rd_count);
        compare_count("lru fill C l2 writes", wr0, l2_wr_count);
        read_check("lru A kept after C", a, lat);
        compare_count("lru A kept after C l2 reads", rd0 + 1, l2_rd_count);
        write_check("lru write A", a, 32'hA5A5_0001, lat);
        // c is least recent, a clean eviction
        rd0 = l2_rd_count;
        wr0 = l2_wr_count;
        read_check("lru fill D", d, lat);
        compare_count("lru fill D l2 reads", rd0 + 1, l2_rd_count);
        compare_count("lru fill D l2 writes", wr0, l2_wr_count);
        // now dirty a is least recent
        exp_wb.op   = MEM_WRITE;
        exp_wb.addr = {a[31:4], 4'b0};
        exp_wb.line = ref_line({a[31:4], 4'b0});
        read_check("lru fill E", e, lat);
        compare_count("lru fill E l2 reads", rd0 + 2, l2_rd_count);
        compare_count("lru fill E l2 writes", wr0 + 1, l2_wr_count);
        compare_l2_req("lru writeback of A", exp_wb, l2_last_wr);
        read_check("lru refetch A", a, lat);
        compare_count("lru refetch A l2 writes", wr0 + 1, l2_wr_count);
    endtask

    // four sets and six tags, heavy eviction and writeback traffic
    task automatic random_mix();
        logic [19:0] tag;
        logic [7:0]  index;
        logic [1:0]  offset;
        logic [31:0] addr;
        int          lat;
        for (int n = 0; n < 150; n++) begin
            rng = xorshift32(rng);
            tag    = 20'h00500 + (rng[15:8] % 6);
            index  = 8'h40 + rng[17:16];
            offset = rng[19:18];
            addr   = make_addr(tag, index, offset);
            if (rng[20]) begin
                rng = xorshift32(rng);
                write_check($sformatf("random_mix %0d write", n), addr, rng, lat);
            end else begin
                read_check($sformatf("random_mix %0d read", n), addr, lat);
            end
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        errors        = 0;
        checks        = 0;
        rng           = 32'd45809;
        repeat (10) @(posedge clk_tmp);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        repeat (2) @(posedge clk_tmp);
        #(DRIVE_DELAY);
        read_miss_clean_set();
        read_hit_same_line();
        write_hit_merge();
        lru_eviction();
        random_mix();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // bounds the whole run at 200 accesses of 40 cycles
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not complete",
                 WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/dcache_arrays.sv
// tag, valid, dirty, line and lru storage of the two-way data cache
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_arrays (
    input  logic                  clk_tmp,
    input  logic                  rst_n,
    input  logic [`DC_ADDR_W-1:0] cur_addr,
    input  dcache_pkg::arr_wr_t   arr_wr,
    output dcache_pkg::set_rd_t   set_rd
);
    import dcache_pkg::*;

    logic [`DC_TAG_W-1:0]               tag_mem  [`DC_WAYS][`DC_SETS];
    logic [`DC_LINE_W-1:0]              line_mem [`DC_WAYS][`DC_SETS];
    logic [`DC_WAYS-1:0][`DC_SETS-1:0]  valid_q;
    logic [`DC_WAYS-1:0][`DC_SETS-1:0]  dirty_q;
    logic [`DC_SETS-1:0]                lru_q;
    logic [`DC_INDEX_W-1:0]             idx;
    logic                               line_we;

    assign idx     = cur_addr[`DC_INDEX_LSB +: `DC_INDEX_W];  // same index for read and write
    assign line_we = (arr_wr.op == ARR_WRITE_HIT) || (arr_wr.op == ARR_FILL);

    // state bits per set
    always_ff @(posedge clk_tmp or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            case (arr_wr.op)
                ARR_TOUCH: begin
                    lru_q[idx] <= ~arr_wr.way;
                end
                ARR_WRITE_HIT: begin
                    dirty_q[arr_wr.way][idx] <= 1'b1;
                    lru_q[idx]               <= ~arr_wr.way;
                end
                ARR_FILL: begin
                    valid_q[arr_wr.way][idx] <= 1'b1;
                    dirty_q[arr_wr.way][idx] <= 1'b0;  // fresh copy of l2
                    lru_q[idx]               <= ~arr_wr.way;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (line_we) begin
            line_mem[arr_wr.way][idx] <= arr_wr.line;
        end
        if (arr_wr.op == ARR_FILL) begin
            tag_mem[arr_wr.way][idx] <= arr_wr.tag;
        end
    end

    // combinational read of the addressed set
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            set_rd.way[w].valid = valid_q[w][idx];
            set_rd.way[w].dirty = dirty_q[w][idx];
            set_rd.way[w].tag   = tag_mem[w][idx];
            set_rd.way[w].line  = line_mem[w][idx];
        end
        set_rd.lru = lru_q[idx];
    end

    // the controller must never leave the command floating once out of reset
    a_op_known: assert property (
        @(posedge clk_tmp) disable iff (!rst_n) !$isunknown(arr_wr.op)
    ) else $error("dcache_arrays: unknown storage command");

endmodule

`default_nettype wire

//--- verilog/dcache_cfg.svh
// address split, way count, set count and line width of the data cache
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cpu address and data word
`define DC_ADDR_W      32
`define DC_WORD_W      32

// address split: tag | index | word offset | byte offset
`define DC_OFFSET_W    2              // word within a line
`define DC_OFFSET_LSB  2              // byte offset bits below it
`define DC_INDEX_W     8
`define DC_INDEX_LSB   4              // first index bit, also line alignment
`define DC_TAG_W       20
`define DC_TAG_LSB     12

// geometry
`define DC_LINE_W      128            // four words per line
`define DC_SETS        256
`define DC_WAYS        2

`endif

//--- verilog/dcache_ctrl.sv
// request register, miss FSM, cpu response and l2 strobes of the data cache
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                   clk_tmp,
    input  logic                   rst_n,
    input  logic                   cpu_req_valid,
    input  dcache_pkg::cpu_req_t   cpu_req,
    output logic                   busy,
    output logic                   cpu_rsp_valid,
    output logic [`DC_WORD_W-1:0]  cpu_rdata,
    output logic [`DC_ADDR_W-1:0]  cur_addr,
    output logic [`DC_WORD_W-1:0]  wr_word,
    output dcache_pkg::arr_wr_t    arr_wr,
    input  dcache_pkg::lookup_t    lkp,
    output logic                   l2_req_valid,
    output dcache_pkg::l2_req_t    l2_req,
    input  logic                   l2_rsp_valid,
    input  logic [`DC_LINE_W-1:0]  l2_rdata
);
    import dcache_pkg::*;

    ctrl_state_e             state_q;
    cpu_req_t                req_q;
    logic                    accept;
    logic [`DC_TAG_W-1:0]    req_tag;
    logic [`DC_INDEX_W-1:0]  req_index;
    l2_req_t                 wb_req;
    l2_req_t                 fill_req;

    assign accept    = (state_q == IDLE) && cpu_req_valid;  // the response cycle is IDLE too
    assign cur_addr  = req_q.addr;
    assign wr_word   = req_q.wdata;
    assign req_tag   = req_q.addr[`DC_TAG_LSB +: `DC_TAG_W];
    assign req_index = req_q.addr[`DC_INDEX_LSB +: `DC_INDEX_W];

    // victim goes back under its old tag, same index
    assign wb_req.op   = MEM_WRITE;
    assign wb_req.addr = {lkp.victim_tag, req_index, {`DC_INDEX_LSB{1'b0}}};
    assign wb_req.line = lkp.victim_line;

    assign fill_req.op   = MEM_READ;
    assign fill_req.addr = {req_tag, req_index, {`DC_INDEX_LSB{1'b0}}};
    assign fill_req.line = '0;

    always_ff @(posedge clk_tmp) begin
        if (accept) begin
            req_q <= cpu_req;
        end
    end

    always_ff @(posedge clk_tmp or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= IDLE;
            busy          <= 1'b0;
            cpu_rsp_valid <= 1'b0;
            l2_req_valid  <= 1'b0;
        end else begin
            cpu_rsp_valid <= (state_q == RESPOND);
            busy          <= (state_q != IDLE) || cpu_req_valid;
            l2_req_valid  <= 1'b0;  // single cycle strobe
            case (state_q)
                IDLE: begin
                    if (cpu_req_valid) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (lkp.hit) begin
                        state_q <= RESPOND;
                    end else if (lkp.victim_dirty) begin
                        state_q      <= WRITEBACK;
                        l2_req_valid <= 1'b1;
                    end else begin
                        state_q      <= REFILL;
                        l2_req_valid <= 1'b1;
                    end
                end
                RESPOND: begin
                    state_q <= IDLE;
                end
                WRITEBACK: begin
                    state_q <= WB_WAIT;
                end
                WB_WAIT: begin
                    if (l2_rsp_valid) begin  // writeback done, now fetch
                        state_q      <= REFILL;
                        l2_req_valid <= 1'b1;
                    end
                end
                REFILL: begin
                    state_q <= FILL_WAIT;
                end
                FILL_WAIT: begin
                    if (l2_rsp_valid) begin
                        state_q <= LOOKUP;  // retry, now a hit
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // response word and l2 request payload
    always_ff @(posedge clk_tmp) begin
        if (state_q == RESPOND) begin
            cpu_rdata <= (req_q.op == MEM_WRITE) ? req_q.wdata : lkp.rd_word;
        end
        if ((state_q == LOOKUP) && !lkp.hit) begin
            l2_req <= lkp.victim_dirty ? wb_req : fill_req;
        end else if ((state_q == WB_WAIT) && l2_rsp_valid) begin
            l2_req <= fill_req;
        end
    end

    // storage command, written at the end of RESPOND or on the fill response
    always_comb begin
        arr_wr.op   = ARR_NONE;
        arr_wr.way  = lkp.hit_way;
        arr_wr.tag  = req_tag;
        arr_wr.line = lkp.merged_line;
        if (state_q == RESPOND) begin
            arr_wr.op = (req_q.op == MEM_WRITE) ? ARR_WRITE_HIT : ARR_TOUCH;
        end else if ((state_q == FILL_WAIT) && l2_rsp_valid) begin
            arr_wr.op   = ARR_FILL;
            arr_wr.way  = lkp.victim_way;
            arr_wr.line = l2_rdata;
        end
    end

    a_rsp_busy: assert property (
        @(posedge clk_tmp) disable iff (!rst_n) cpu_rsp_valid |-> busy
    ) else $error("dcache_ctrl: response without busy");

    // a strobe during the response cycle is legal, the slot is free then
    a_req_not_busy: assert property (
        @(posedge clk_tmp) disable iff (!rst_n) cpu_req_valid |-> (!busy || cpu_rsp_valid)
    ) else $error("dcache_ctrl: cpu request while busy");

    a_l2_one_outstanding: assert property (
        @(posedge clk_tmp) disable iff (!rst_n)
        ((state_q == WB_WAIT) || (state_q == FILL_WAIT)) |-> !l2_req_valid
    ) else $error("dcache_ctrl: l2 strobe while waiting for l2");

endmodule

`default_nettype wire

//--- verilog/dcache_lookup.sv
// tag compare, word select, word merge and victim choice for one set
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_lookup (
    input  logic [`DC_ADDR_W-1:0] cur_addr,
    input  logic [`DC_WORD_W-1:0] wr_word,
    input  dcache_pkg::set_rd_t   set_rd,
    output dcache_pkg::lookup_t   lkp
);
    import dcache_pkg::*;

    logic [`DC_TAG_W-1:0]    addr_tag;
    logic [`DC_OFFSET_W-1:0] offset;
    logic                    hit0;
    logic                    hit1;
    way_e                    hit_way;
    way_e                    vic_way;
    way_entry_t              hit_entry;
    way_entry_t              vic_entry;
    logic [`DC_LINE_W-1:0]   merged;

    assign addr_tag = cur_addr[`DC_TAG_LSB +: `DC_TAG_W];
    assign offset   = cur_addr[`DC_OFFSET_LSB +: `DC_OFFSET_W];

    assign hit0 = set_rd.way[WAY0].valid && (set_rd.way[WAY0].tag == addr_tag);
    assign hit1 = set_rd.way[WAY1].valid && (set_rd.way[WAY1].tag == addr_tag);

    assign hit_way   = hit0 ? WAY0 : WAY1;  // meaningless without a hit
    assign hit_entry = set_rd.way[hit_way];

    // invalid way first, then the lru pointer
    always_comb begin
        if (!set_rd.way[WAY0].valid) begin
            vic_way = WAY0;
        end else if (!set_rd.way[WAY1].valid) begin
            vic_way = WAY1;
        end else begin
            vic_way = way_e'(set_rd.lru);
        end
    end

    assign vic_entry = set_rd.way[vic_way];

    // store data dropped into the hit line
    always_comb begin
        merged = hit_entry.line;
        merged[offset*`DC_WORD_W +: `DC_WORD_W] = wr_word;
    end

    always_comb begin
        lkp.hit          = hit0 || hit1;
        lkp.hit_way      = hit_way;
        lkp.rd_word      = hit_entry.line[offset*`DC_WORD_W +: `DC_WORD_W];
        lkp.merged_line  = merged;
        lkp.victim_way   = vic_way;
        lkp.victim_dirty = vic_entry.valid && vic_entry.dirty;  // needs writeback
        lkp.victim_tag   = vic_entry.tag;
        lkp.victim_line  = vic_entry.line;
    end

endmodule

`default_nettype wire

//--- verilog/dcache_pkg.sv
// enums and packed structs shared by the data cache RTL and testbench
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

    typedef enum logic {MEM_READ = 1'b0, MEM_WRITE = 1'b1} mem_op_e;

    typedef enum logic {WAY0 = 1'b0, WAY1 = 1'b1} way_e;

    // storage commands
    typedef enum logic [1:0] {
        ARR_NONE      = 2'd0,
        ARR_TOUCH     = 2'd1,         // lru only
        ARR_WRITE_HIT = 2'd2,         // line, dirty set, lru
        ARR_FILL      = 2'd3          // tag, valid, line, dirty clear, lru
    } arr_op_e;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        RESPOND   = 3'd2,
        WRITEBACK = 3'd3,
        WB_WAIT   = 3'd4,
        REFILL    = 3'd5,
        FILL_WAIT = 3'd6
    } ctrl_state_e;

    typedef struct packed {
        mem_op_e                op;
        logic [`DC_ADDR_W-1:0]  addr;
        logic [`DC_WORD_W-1:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        mem_op_e                op;
        logic [`DC_ADDR_W-1:0]  addr;   // line aligned
        logic [`DC_LINE_W-1:0]  line;
    } l2_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_LINE_W-1:0]  line;
    } way_entry_t;

    typedef struct packed {
        way_entry_t [`DC_WAYS-1:0] way;
        logic                      lru;  // names the next victim
    } set_rd_t;

    typedef struct packed {
        arr_op_e                op;
        way_e                   way;
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_LINE_W-1:0]  line;
    } arr_wr_t;

    typedef struct packed {
        logic                   hit;
        way_e                   hit_way;
        logic [`DC_WORD_W-1:0]  rd_word;
        logic [`DC_LINE_W-1:0]  merged_line;
        way_e                   victim_way;
        logic                   victim_dirty;  // valid and dirty
        logic [`DC_TAG_W-1:0]   victim_tag;
        logic [`DC_LINE_W-1:0]  victim_line;
    } lookup_t;

endpackage

`default_nettype wire

//--- verilog/dcache_top.sv
// top level of the two-way write-back data cache
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_top (
    input  logic                   clk_tmp,
    input  logic                   rst_n,
    input  logic                   cpu_req_valid,
    input  dcache_pkg::cpu_req_t   cpu_req,
    output logic                   busy,
    output logic                   cpu_rsp_valid,
    output logic [`DC_WORD_W-1:0]  cpu_rdata,
    output logic                   l2_req_valid,
    output dcache_pkg::l2_req_t    l2_req,
    input  logic                   l2_rsp_valid,
    input  logic [`DC_LINE_W-1:0]  l2_rdata
);
    import dcache_pkg::*;

    logic [`DC_ADDR_W-1:0]  cur_addr;   // registered request address
    logic [`DC_WORD_W-1:0]  wr_word;
    arr_wr_t                arr_wr;
    set_rd_t                set_rd;
    lookup_t                lkp;

    dcache_ctrl dcache_ctrl_inst (
        .clk_tmp       (clk_tmp),
        .rst_n         (rst_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .busy          (busy),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rdata     (cpu_rdata),
        .cur_addr      (cur_addr),
        .wr_word       (wr_word),
        .arr_wr        (arr_wr),
        .lkp           (lkp),
        .l2_req_valid  (l2_req_valid),
        .l2_req        (l2_req),
        .l2_rsp_valid  (l2_rsp_valid),
        .l2_rdata      (l2_rdata)
    );

    dcache_arrays dcache_arrays_inst (
        .clk_tmp  (clk_tmp),
        .rst_n    (rst_n),
        .cur_addr (cur_addr),
        .arr_wr   (arr_wr),
        .set_rd   (set_rd)
    );

    // purely combinational, sees the set addressed by cur_addr
    dcache_lookup dcache_lookup_inst (
        .cur_addr (cur_addr),
        .wr_word  (wr_word),
        .set_rd   (set_rd),
        .lkp      (lkp)
    );

endmodule

`default_nettype wire
